/* bench/ein_line_monitor.sv */
`timescale 1ns/1ps

module ein_line_monitor (
	input  logic       clk,
	input  logic       bit_ctr_reset,
	input  logic       goc,
	input  logic       emo,
	input  logic       edi,
	input  logic       eci,
	output logic [7:0] rx_byte,
	output logic       rx_valid,
	output logic       frame_err
);

	logic       prev_eci;
	logic       close_next;  // goc, next eci rise ends the bit
	logic       seen_mark;   // edi high since last eci fall
	logic [7:0] shreg;
	logic [2:0] nbits;

	// line wires are sampled mid cycle, away from the clock edge
	always @(negedge clk) begin
		if (bit_ctr_reset) begin
			prev_eci   <= 1'b0;
			close_next <= 1'b0;
			seen_mark  <= 1'b0;
			shreg      <= 8'd0;
			nbits      <= 3'd0;
			rx_byte    <= 8'd0;
			rx_valid   <= 1'b0;
			frame_err  <= 1'b0;
		end else begin
			prev_eci  <= eci;
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;
			if (prev_eci && !eci)
				seen_mark <= edi;
			else if (!eci && edi)
				seen_mark <= 1'b1;
			if (eci && !prev_eci) begin
				if (!emo) begin
					$display("line monitor: eci rose while emo was low");
					frame_err <= 1'b1;
				end
				if (goc && close_next) begin
					close_next <= 1'b0;
					if (edi) begin
						$display("line monitor: goc bit not closed with edi low");
						frame_err <= 1'b1;
					end
				end else begin
					if (goc && !seen_mark) begin
						$display("line monitor: goc bit without edi high marker");
						frame_err <= 1'b1;
					end
					close_next <= goc;
					shreg      <= {edi, shreg[7:1]};  // lsb first
					nbits      <= nbits + 3'd1;
					if (nbits == 3'd7) begin
						rx_byte  <= {edi, shreg[7:1]};
						rx_valid <= 1'b1;
					end
				end
			end
		end
	end

endmodule

/* bench/ein_tb.sv */
`timescale 1ns/1ps

module ein_tb;

	import ein_pkg::*;

	typedef struct packed {
		logic       goc;
		logic       frag;
		logic [7:0] div;
		logic [4:0] count;
		logic [7:0] first;
	} row_t;

	localparam int NUM_ROWS = 8;

	// goc, fragment, divider, byte count, first byte
	row_t rows [NUM_ROWS] = '{
		'{1'b0, 1'b0, 8'd8, 5'd3,  8'hA5},
		'{1'b1, 1'b0, 8'd6, 5'd4,  8'h3C},
		'{1'b0, 1'b0, 8'd4, 5'd16, 8'h01},  // fills the fifo
		'{1'b1, 1'b1, 8'd5, 5'd2,  8'hF0},
		'{1'b1, 1'b1, 8'd5, 5'd3,  8'h0F},  // continues the open frame
		'{1'b1, 1'b0, 8'd5, 5'd1,  8'h81},  // closes it
		'{1'b0, 1'b1, 8'd4, 5'd2,  8'h5A},
		'{1'b0, 1'b0, 8'd4, 5'd1,  8'hC3}
	};

	logic                  clk;
	logic                  bit_ctr_reset;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [EIN_ADDR_W-1:0] paddr;
	logic [EIN_DATA_W-1:0] pwdata;
	logic [EIN_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  emo;
	logic                  edi;
	logic                  eci;
	logic                  mon_goc;
	logic [7:0]            rx_byte;
	logic                  rx_valid;
	logic                  frame_err;
	logic [7:0]            exp_q [$];
	logic [7:0]            want_byte;
	logic [31:0]           rd;
	logic                  err;
	int                    cycle_count = 0;
	int                    cycle_limit;

	ein_link_top dut0 (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.emo           (emo),
		.edi           (edi),
		.eci           (eci)
	);

	ein_line_monitor u_mon (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.goc           (mon_goc),
		.emo           (emo),
		.edi           (edi),
		.eci           (eci),
		.rx_byte       (rx_byte),
		.rx_valid      (rx_valid),
		.frame_err     (frame_err)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_with_error();
		$display("Finished with errors");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want);
			stop_with_error();
		end
	endtask

	function automatic int timeout_cycles();
		int total;
		total = 2000;
		foreach (rows[i])
			total += 5 * 8 * int'(rows[i].div) * int'(rows[i].count);
		return total;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// apb access tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_xfer(input logic wr, input logic [EIN_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic xerr);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;  // access cycle
		rdata = prdata;
		xerr  = pslverr;
		check("pready", 32'(pready), 32'd1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic reg_write(input logic [EIN_ADDR_W-1:0] addr, input logic [31:0] data,
			input logic want_err);
		logic [31:0] dummy;
		logic        xerr;
		apb_xfer(1'b1, addr, data, dummy, xerr);
		check("pslverr", 32'(xerr), 32'(want_err));
	endtask

	task automatic reg_read(input logic [EIN_ADDR_W-1:0] addr, output logic [31:0] data);
		logic xerr;
		apb_xfer(1'b0, addr, 32'd0, data, xerr);
		check("pslverr", 32'(xerr), 32'd0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// configure, fill, send and drain one table row
	////////////////////////////////////////////////////////////////////////////

	task automatic run_row(input row_t row);
		logic [31:0] st;
		logic [31:0] want;
		logic [7:0]  b;
		int          i;
		mon_goc = row.goc;
		reg_write(EIN_REG_CTRL, {30'd0, row.frag, row.goc}, 1'b0);
		reg_write(EIN_REG_CLK_DIV, 32'(row.div), 1'b0);
		for (i = 0; i < int'(row.count); i++) begin
			b = (i == 0) ? row.first : 8'($urandom());
			reg_write(EIN_REG_TXDATA, 32'(b), 1'b0);
			exp_q.push_back(b);
		end
		want = 32'(row.count);
		if (row.count == 5'd16)
			want[EIN_STAT_FULL_BIT] = 1'b1;
		reg_read(EIN_REG_STATUS, st);
		check("status", st, want);
		if (row.count == 5'd16) begin
			reg_write(EIN_REG_TXDATA, 32'hEE, 1'b1);  // one too many
			reg_read(EIN_REG_STATUS, st);
			check("status", st, want);
		end
		reg_write(EIN_REG_CMD, 32'd1, 1'b0);
		reg_read(EIN_REG_STATUS, st);
		check("status.busy", 32'(st[EIN_STAT_BUSY_BIT]), 32'd1);
		while (st[EIN_STAT_BUSY_BIT])
			reg_read(EIN_REG_STATUS, st);
		check("status", st, 32'd0);
		check("bytes pending", 32'(exp_q.size()), 32'd0);
		check("emo", 32'(emo), 32'(row.frag));  // frame stays open in fragment mode
	endtask

	// decoded bytes against the pushed ones
	always @(posedge clk) begin
		if (frame_err) begin
			stop_with_error();
		end else if (rx_valid) begin
			if (exp_q.size() == 0) begin
				$display("line monitor decoded byte 0x%0h with no byte pending", rx_byte);
				stop_with_error();
			end else begin
				want_byte = exp_q.pop_front();
				check("rx_byte", 32'(rx_byte), 32'(want_byte));
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run went past %0d clock cycles", cycle_limit);
			stop_with_error();
		end
	end

	initial begin
		bit_ctr_reset = 1'b1;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		mon_goc       = 1'b0;
		void'($urandom(97));
		cycle_limit = timeout_cycles();
		repeat (3) @(posedge clk);
		#1;
		bit_ctr_reset = 1'b0;
		check("emo", 32'(emo), 32'd0);
		check("edi", 32'(edi), 32'd0);
		check("eci", 32'(eci), 32'd0);
		reg_read(EIN_REG_CTRL, rd);
		check("ctrl", rd, 32'd0);
		reg_read(EIN_REG_CLK_DIV, rd);
		check("clk_div", rd, 32'(EIN_CLK_DIV_RESET));
		reg_read(EIN_REG_STATUS, rd);
		check("status", rd, 32'd0);
		reg_write(EIN_REG_CTRL, 32'd3, 1'b0);
		reg_read(EIN_REG_CTRL, rd);
		check("ctrl", rd, 32'd3);
		reg_write(EIN_REG_CLK_DIV, 32'h123, 1'b0);
		reg_write(EIN_REG_CLK_DIV, 32'd3, 1'b1);  // below minimum
		reg_read(EIN_REG_CLK_DIV, rd);
		check("clk_div", rd, 32'h123);
		reg_write(8'h20, 32'd0, 1'b1);
		apb_xfer(1'b0, 8'h20, 32'd0, rd, err);
		check("pslverr", 32'(err), 32'd1);
		foreach (rows[r])
			run_row(rows[r]);
		reg_read(EIN_REG_TXDATA, rd);  // fifo memory and push data now hold bytes
		check("txdata", rd, 32'd0);
		reg_read(EIN_REG_CMD, rd);
		check("cmd", rd, 32'd0);
		$display("Finished with no errors");
		$finish;
	end

endmodule

/* common/ein_pkg.sv */
package ein_pkg;

	////////////////////////////////////////////////////////////////////////////
	// bus and datapath widths
	////////////////////////////////////////////////////////////////////////////

	localparam int unsigned EIN_ADDR_W      = 8;
	localparam int unsigned EIN_DATA_W      = 32;
	localparam int unsigned EIN_CLK_DIV_W   = 24;
	localparam int unsigned EIN_CLK_DIV_MIN = 4;   // below this mid-POS2 hits phase end
	localparam int unsigned EIN_FIFO_DEPTH  = 16;  // power of two, pointers wrap
	localparam int unsigned EIN_FIFO_LVL_W  = 5;

	localparam logic [EIN_CLK_DIV_W-1:0] EIN_CLK_DIV_RESET = 24'd8;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [EIN_ADDR_W-1:0] EIN_REG_CTRL    = 8'h00;
	localparam logic [EIN_ADDR_W-1:0] EIN_REG_CLK_DIV = 8'h04;
	localparam logic [EIN_ADDR_W-1:0] EIN_REG_TXDATA  = 8'h08;  // write only
	localparam logic [EIN_ADDR_W-1:0] EIN_REG_CMD     = 8'h0C;  // write only, bit0 start
	localparam logic [EIN_ADDR_W-1:0] EIN_REG_STATUS  = 8'h10;  // read only

	localparam int unsigned EIN_CTRL_GOC_BIT  = 0;
	localparam int unsigned EIN_CTRL_FRAG_BIT = 1;
	localparam int unsigned EIN_STAT_BUSY_BIT = 8;
	localparam int unsigned EIN_STAT_FULL_BIT = 9;

	// transmitter phases, one bit is NEG1 NEG2 POS1 [POS1B] POS2
	typedef enum logic [2:0] {
		IDLE,
		START,
		NEG1,
		NEG2,
		POS1,
		POS1B,      // goc mode only
		POS2,
		FRAG_WAIT   // emo held high between fragments
	} ein_tx_state_t;

endpackage

/* design/ein_apb_regs.sv */
`timescale 1ns/1ps

module ein_apb_regs (
	input  logic                               clk,
	input  logic                               bit_ctr_reset,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [ein_pkg::EIN_ADDR_W-1:0]     paddr,
	input  logic [ein_pkg::EIN_DATA_W-1:0]     pwdata,
	output logic [ein_pkg::EIN_DATA_W-1:0]     prdata,
	output logic                               pready,
	output logic                               pslverr,
	input  logic                               fifo_full,
	input  logic [ein_pkg::EIN_FIFO_LVL_W-1:0] fifo_level,
	input  logic                               tx_busy,
	output logic                               push,
	output logic [7:0]                         push_data,
	output logic [ein_pkg::EIN_CLK_DIV_W-1:0]  clk_div,
	output logic                               goc_mode,
	output logic                               fragment,
	output logic                               start_tx
);

	import ein_pkg::*;

	logic                  access;
	logic                  addr_ok;
	logic                  wr_err;
	logic                  wr_ok;
	logic [EIN_DATA_W-1:0] rd_word;

	assign access = psel && penable;  // zero wait, access cycle completes
	assign pready = 1'b1;

	////////////////////////////////////////////////////////////////////////////
	// decode and read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		addr_ok = 1'b1;
		rd_word = '0;
		case (paddr)
			EIN_REG_CTRL: begin
				rd_word[EIN_CTRL_GOC_BIT]  = goc_mode;
				rd_word[EIN_CTRL_FRAG_BIT] = fragment;
			end
			EIN_REG_CLK_DIV: begin
				rd_word[EIN_CLK_DIV_W-1:0] = clk_div;
			end
			EIN_REG_TXDATA, EIN_REG_CMD: begin
				rd_word = '0;  // write only, reads as zero
			end
			EIN_REG_STATUS: begin
				rd_word[EIN_FIFO_LVL_W-1:0] = fifo_level;
				rd_word[EIN_STAT_BUSY_BIT]  = tx_busy;
				rd_word[EIN_STAT_FULL_BIT]  = fifo_full;
			end
			default: begin
				addr_ok = 1'b0;
			end
		endcase
	end

	// rejected writes leave all state alone
	assign wr_err = pwrite && (((paddr == EIN_REG_TXDATA) && fifo_full) ||
		((paddr == EIN_REG_CLK_DIV) && (pwdata[EIN_CLK_DIV_W-1:0] < EIN_CLK_DIV_MIN)));

	assign pslverr = access && (!addr_ok || wr_err);
	assign wr_ok   = access && pwrite && addr_ok && !wr_err;
	assign prdata  = (access && !pwrite) ? rd_word : '0;

	////////////////////////////////////////////////////////////////////////////
	// registers and strobes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			goc_mode <= 1'b0;
			fragment <= 1'b0;
			clk_div  <= EIN_CLK_DIV_RESET;
			push     <= 1'b0;
			start_tx <= 1'b0;
		end else begin
			push     <= wr_ok && (paddr == EIN_REG_TXDATA);  // one cycle strobe
			start_tx <= wr_ok && (paddr == EIN_REG_CMD) && pwdata[0];
			if (wr_ok && (paddr == EIN_REG_CTRL)) begin
				goc_mode <= pwdata[EIN_CTRL_GOC_BIT];
				fragment <= pwdata[EIN_CTRL_FRAG_BIT];
			end
			if (wr_ok && (paddr == EIN_REG_CLK_DIV))
				clk_div <= pwdata[EIN_CLK_DIV_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok && (paddr == EIN_REG_TXDATA))
			push_data <= pwdata[7:0];
	end

	// push trails an accepted access, pslverr belongs to a rejected one
	a_push_not_err: assert property (@(posedge clk) disable iff (bit_ctr_reset)
		!(push && pslverr));

endmodule

/* design/ein_byte_fifo.sv */
`timescale 1ns/1ps

module ein_byte_fifo (
	input  logic                               clk,
	input  logic                               bit_ctr_reset,
	input  logic                               push,
	input  logic [7:0]                         push_data,
	input  logic                               pop,
	output logic [7:0]                         head,
	output logic                               empty,
	output logic                               full,
	output logic [ein_pkg::EIN_FIFO_LVL_W-1:0] level
);

	import ein_pkg::*;

	logic [7:0]                mem [0:EIN_FIFO_DEPTH-1];
	logic [EIN_FIFO_LVL_W-2:0] wr_ptr;  // wraps at depth
	logic [EIN_FIFO_LVL_W-2:0] rd_ptr;

	assign head  = mem[rd_ptr];  // fall through, no read latency
	assign empty = (level == '0);
	assign full  = (level == EIN_FIFO_LVL_W'(EIN_FIFO_DEPTH));

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: begin
					level <= level + 1'b1;
				end
				2'b01: begin
					level <= level - 1'b1;
				end
				default: begin
					level <= level;  // both or neither
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// neighbours must respect the flags
	////////////////////////////////////////////////////////////////////////////

	a_no_pop_empty: assert property (@(posedge clk) disable iff (bit_ctr_reset)
		pop |-> !empty);

	a_no_push_full: assert property (@(posedge clk) disable iff (bit_ctr_reset)
		push |-> !full);

endmodule

/* design/ein_link_top.sv */
`timescale 1ns/1ps

module ein_link_top (
	input  logic                           clk,
	input  logic                           bit_ctr_reset,
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [ein_pkg::EIN_ADDR_W-1:0] paddr,
	input  logic [ein_pkg::EIN_DATA_W-1:0] pwdata,
	output logic [ein_pkg::EIN_DATA_W-1:0] prdata,
	output logic                           pready,
	output logic                           pslverr,
	output logic                           emo,
	output logic                           edi,
	output logic                           eci
);

	import ein_pkg::*;

	logic                      push;
	logic [7:0]                push_data;
	logic                      fifo_full;
	logic [EIN_FIFO_LVL_W-1:0] fifo_level;
	logic [7:0]                head;
	logic                      empty;
	logic                      pop;
	logic [EIN_CLK_DIV_W-1:0]  clk_div;
	logic                      goc_mode;
	logic                      fragment;
	logic                      start_tx;
	logic                      tx_busy;

	ein_apb_regs u_regs (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.fifo_full     (fifo_full),
		.fifo_level    (fifo_level),
		.tx_busy       (tx_busy),
		.push          (push),
		.push_data     (push_data),
		.clk_div       (clk_div),
		.goc_mode      (goc_mode),
		.fragment      (fragment),
		.start_tx      (start_tx)
	);

	ein_byte_fifo u_fifo (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.push          (push),
		.push_data     (push_data),
		.pop           (pop),
		.head          (head),
		.empty         (empty),
		.full          (fifo_full),
		.level         (fifo_level)
	);

	ein_tx u_tx (
		.clk           (clk),
		.bit_ctr_reset (bit_ctr_reset),
		.head          (head),
		.empty         (empty),
		.clk_div       (clk_div),
		.goc_mode      (goc_mode),
		.fragment      (fragment),
		.start_tx      (start_tx),
		.pop           (pop),
		.busy          (tx_busy),
		.emo           (emo),
		.edi           (edi),
		.eci           (eci)
	);

endmodule

/* ein_tx/ein_tx.sv */
`timescale 1ns/1ps

module ein_tx (
	input  logic                              clk,
	input  logic                              bit_ctr_reset,
	input  logic [7:0]                        head,
	input  logic                              empty,
	input  logic [ein_pkg::EIN_CLK_DIV_W-1:0] clk_div,
	input  logic                              goc_mode,
	input  logic                              fragment,
	input  logic                              start_tx,
	output logic                              pop,
	output logic                              busy,
	output logic                              emo,
	output logic                              edi,
	output logic                              eci
);

	import ein_pkg::*;

	ein_tx_state_t            state;
	ein_tx_state_t            next_state;
	logic [EIN_CLK_DIV_W-1:0] state_ctr;
	logic [2:0]               bit_ctr;
	logic                     bit_ctr_incr;
	logic                     bit_ctr_clear;
	logic                     phase_end;
	logic                     phase_mid;
	logic                     next_emo;
	logic                     next_edi;
	logic                     next_eci;

	assign phase_end = (state_ctr == clk_div - 1'b1);
	assign phase_mid = (state_ctr == (clk_div >> 1));

	assign pop  = bit_ctr_incr && (bit_ctr == 3'd7);  // byte done after its last bit
	assign busy = (state != IDLE) && (state != FRAG_WAIT);

	////////////////////////////////////////////////////////////////////////////
	// state, phase counter, bit index, line registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (bit_ctr_reset) begin
			state     <= IDLE;
			state_ctr <= '0;
			bit_ctr   <= 3'd0;
			emo       <= 1'b0;
			edi       <= 1'b0;
			eci       <= 1'b0;
		end else begin
			state <= next_state;
			emo   <= next_emo;
			edi   <= next_edi;
			eci   <= next_eci;
			if (next_state != state)
				state_ctr <= '0;  // restart each phase
			else
				state_ctr <= state_ctr + 1'b1;
			if (bit_ctr_clear)
				bit_ctr <= 3'd0;
			else if (bit_ctr_incr)
				bit_ctr <= bit_ctr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// phase sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state    = state;
		next_emo      = 1'b1;
		next_edi      = 1'b0;
		next_eci      = 1'b0;
		bit_ctr_incr  = 1'b0;
		bit_ctr_clear = 1'b0;
		case (state)
			IDLE: begin
				next_emo = 1'b0;
				if (start_tx)
					next_state = START;
			end
			START: begin
				bit_ctr_clear = 1'b1;
				if (phase_end)
					next_state = NEG1;
			end
			NEG1: begin
				next_edi = goc_mode ? 1'b1 : edi;  // goc marker before the bit
				if (phase_end)
					next_state = NEG2;
			end
			NEG2: begin
				next_edi = head[bit_ctr];
				if (phase_end)
					next_state = POS1;
			end
			POS1: begin
				next_eci = 1'b1;
				next_edi = head[bit_ctr];
				if (phase_end)
					next_state = goc_mode ? POS1B : POS2;
			end
			POS1B: begin
				next_edi = head[bit_ctr];  // data held while eci is low
				if (phase_end)
					next_state = POS2;
			end
			POS2: begin
				next_eci = 1'b1;
				next_edi = goc_mode ? 1'b0 : edi;
				if (phase_mid) begin
					bit_ctr_incr = 1'b1;
				end else if (phase_end) begin
					if (!empty)
						next_state = NEG1;
					else if (fragment)
						next_state = FRAG_WAIT;
					else
						next_state = IDLE;
				end
			end
			FRAG_WAIT: begin
				if (start_tx)
					next_state = START;  // continue same frame
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// divider from the register block must allow a distinct mid point
	a_div_min: assert property (@(posedge clk) disable iff (bit_ctr_reset)
		busy |-> (clk_div >= EIN_CLK_DIV_MIN));

	// no strobe while the line is idle
	a_eci_idle: assert property (@(posedge clk) disable iff (bit_ctr_reset)
		!emo |-> !eci);

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal \
		-f vlog.f --top-module ein_tb -o ein_sim \
	&& ./obj_dir/ein_sim \
	|| { echo "simulation run failed"; exit 1; }

/* vlog.f */
common/ein_pkg.sv
design/ein_apb_regs.sv
design/ein_byte_fifo.sv
ein_tx/ein_tx.sv
design/ein_link_top.sv
bench/ein_line_monitor.sv
bench/ein_tb.sv
